// File: hdl/mrx_pkg.sv
package mrx_pkg;

   //############################
   // packet layout
   //############################

   localparam int PW = 104;            // packet width, sum of packet fields

   // access size, 1/2/4/8 bytes
   typedef enum logic [1:0] {
      size_byte   = 2'd0,
      size_half   = 2'd1,
      size_word   = 2'd2,
      size_double = 2'd3
   } mrx_size_t;

   // opcode carried in the top packet bit
   typedef enum logic {
      cmd_read  = 1'b0,
      cmd_write = 1'b1
   } mrx_cmd_t;

   // wide packet, msb first
   typedef struct packed {
      mrx_cmd_t    write;              // read/write select
      mrx_size_t   datamode;           // access size
      logic [4:0]  ctrlmode;           // opaque control bits
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;            // return address for reads
   } mrx_packet_t;

   // framing fsm
   typedef enum logic {
      mrx_idle = 1'b0,
      mrx_busy = 1'b1
   } mrx_state_t;

   // decoded transaction handed to the user
   typedef struct packed {
      mrx_cmd_t    cmd;
      mrx_size_t   size;
      logic [4:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] data;
      logic [31:0] srcaddr;
      logic [7:0]  bytemask;           // lanes touched within the doubleword
      logic        align_err;          // dstaddr not size aligned
   } mrx_txn_t;

endpackage

// File: hdl/mrx_io.sv
`timescale 1ns/1ps

// pin sampling, one flop on access and two on the beat bus
module mrx_io #(
   parameter int NMIO = 8              // half the beat width
) (
   input  logic              rx_clk,
   input  logic              nreset,
   input  logic              io_access,   // framing level from pins
   input  logic [2*NMIO-1:0] io_packet,   // raw beat bus
   output logic              access,      // sampled framing level
   output logic [2*NMIO-1:0] beat         // beat, lined up with shift cycle
);

   logic [2*NMIO-1:0] beat_q;          // first sample of the beat bus

   //############################
   // access level
   //############################

   always_ff @(posedge rx_clk or negedge nreset) begin
      if (!nreset) begin
         access <= 1'b0;
      end else begin
         access <= io_access;
      end
   end

   //############################
   // beat path
   //############################

   // extra stage covers the idle to busy step in the framer
   always_ff @(posedge rx_clk) begin
      beat_q <= io_packet;             // pin sample
      beat   <= beat_q;                // aligned with first busy cycle
   end

endmodule

// File: hdl/mrx_ser2par.sv
`timescale 1ns/1ps

// beat wide shifter, holds the last PW bits shifted in
module mrx_ser2par #(
   parameter int NMIO = 8
) (
   input  logic                   rx_clk,
   input  logic                   shift,     // one beat per busy cycle
   input  logic                   lsbfirst,
   input  logic [2*NMIO-1:0]      din,
   output logic [mrx_pkg::PW-1:0] dout
);

   import mrx_pkg::*;

   localparam int SW = 2*NMIO;         // beat width

   //############################
   // shifter
   //############################

   // payload only, no reset
   always_ff @(posedge rx_clk) begin
      if (shift) begin
         if (lsbfirst) begin
            // move down, new beat enters at the top
            dout <= {din, dout[PW-1:SW]};
         end else begin
            // move up, new beat enters at the bottom
            dout <= {dout[PW-SW-1:0], din};
         end
      end
   end

   // first beats of a packet fall off the far end
   // when datasize*SW exceeds PW, so only the
   // tail of the stream survives

endmodule

// File: hdl/mrx_protocol.sv
`timescale 1ns/1ps

// framing of the beat stream into packets
module mrx_protocol #(
   parameter int NMIO = 8
) (
   input  logic                 rx_clk,
   input  logic                 nreset,
   input  logic [7:0]           datasize,    // beats per packet
   input  logic                 lsbfirst,    // shift order
   input  logic                 access,      // sampled framing level
   input  logic [2*NMIO-1:0]    beat,
   output logic                 fifo_access, // one cycle write strobe
   output mrx_pkg::mrx_packet_t fifo_packet
);

   import mrx_pkg::*;

   localparam int CW = $clog2(2*PW/NMIO); // transfer count width

   mrx_state_t      state;
   logic [CW-1:0]   count;             // beats left in this packet
   logic            shift;
   logic            transfer_done;
   logic [PW-1:0]   shift_data;        // raw shifter contents

   //############################
   // state machine
   //############################

   // idle to busy on access high, back to idle on access low
   always_ff @(posedge rx_clk or negedge nreset) begin
      if (!nreset) begin
         state <= mrx_idle;
      end else begin
         state <= access ? mrx_busy : mrx_idle;
      end
   end

   // beat counter, reload while idle and at each packet end
   always_ff @(posedge rx_clk or negedge nreset) begin
      if (!nreset) begin
         count <= '0;
      end else if ((state == mrx_idle) || transfer_done) begin
         count <= datasize[CW-1:0];
      end else begin
         count <= count - 1'b1;        // busy, one beat per cycle
      end
   end

   assign shift         = (state == mrx_busy);
   assign transfer_done = (state == mrx_busy) && (count == CW'(1)); // last beat shifting

   // strobe lines up with the last beat landing in the shifter
   always_ff @(posedge rx_clk or negedge nreset) begin
      if (!nreset) begin
         fifo_access <= 1'b0;
      end else begin
         fifo_access <= transfer_done;
      end
   end

   //############################
   // shift register
   //############################

   mrx_ser2par #(
      .NMIO (NMIO)
   ) i_ser2par (
      .rx_clk   (rx_clk),
      .shift    (shift),
      .lsbfirst (lsbfirst),
      .din      (beat),
      .dout     (shift_data)
   );

   assign fifo_packet = mrx_packet_t'(shift_data); // view as packet fields

endmodule

// File: hdl/mrx_fifo.sv
`timescale 1ns/1ps

// packet queue with registered read port
module mrx_fifo #(
   parameter int FIFO_DEPTH = 4        // entries, power of two
) (
   input  logic                 rx_clk,
   input  logic                 nreset,
   input  logic                 wr,        // write strobe, never refused
   input  mrx_pkg::mrx_packet_t wr_packet,
   input  logic                 rd,        // pop request
   output logic                 q_valid,   // head valid pulse
   output mrx_pkg::mrx_packet_t q_packet,
   output logic                 empty,
   output logic                 overflow   // sticky until reset
);

   import mrx_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH); // index width

   mrx_packet_t mem [0:FIFO_DEPTH-1];
   logic [AW:0] wr_ptr;                // extra msb tells full from empty
   logic [AW:0] rd_ptr;
   logic        full;
   logic        wr_en;
   logic        rd_en;

   //############################
   // status
   //############################

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                  (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign wr_en = wr && !full;         // full write is dropped
   assign rd_en = rd && !empty;        // rd while empty ignored

   //############################
   // pointers and flags
   //############################

   always_ff @(posedge rx_clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         q_valid  <= 1'b0;
         overflow <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         q_valid <= rd_en;             // head shows up next cycle
         if (wr && full) begin
            overflow <= 1'b1;          // lost packet
         end
      end
   end

   //############################
   // storage
   //############################

   always_ff @(posedge rx_clk) begin
      if (wr_en) begin
         mem[wr_ptr[AW-1:0]] <= wr_packet;
      end
      if (rd_en) begin
         q_packet <= mem[rd_ptr[AW-1:0]]; // registered read port
      end
   end

endmodule

// File: hdl/mrx_unpack.sv
`timescale 1ns/1ps

// packet to transaction decode, one register stage
module mrx_unpack (
   input  logic                 rx_clk,
   input  logic                 nreset,
   input  logic                 q_valid,
   input  mrx_pkg::mrx_packet_t q_packet,
   output logic                 txn_valid,
   output mrx_pkg::mrx_txn_t    txn
);

   import mrx_pkg::*;

   logic [7:0] lane_blk;               // 2^size ones, unshifted
   logic       misalign;
   mrx_txn_t   txn_d;

   //############################
   // decode
   //############################

   always_comb begin
      case (q_packet.datamode)
         size_byte: begin
            lane_blk = 8'h01;
            misalign = 1'b0;           // bytes always aligned
         end
         size_half: begin
            lane_blk = 8'h03;
            misalign = q_packet.dstaddr[0];
         end
         size_word: begin
            lane_blk = 8'h0f;
            misalign = |q_packet.dstaddr[1:0];
         end
         default: begin
            lane_blk = 8'hff;          // doubleword
            misalign = |q_packet.dstaddr[2:0];
         end
      endcase
   end

   always_comb begin
      txn_d.cmd       = q_packet.write;
      txn_d.size      = q_packet.datamode;
      txn_d.ctrlmode  = q_packet.ctrlmode;
      txn_d.dstaddr   = q_packet.dstaddr;
      txn_d.data      = q_packet.data;
      txn_d.srcaddr   = q_packet.srcaddr;
      txn_d.bytemask  = lane_blk << q_packet.dstaddr[2:0]; // upper lanes fall off
      txn_d.align_err = misalign;
   end

   //############################
   // output register
   //############################

   always_ff @(posedge rx_clk or negedge nreset) begin
      if (!nreset) begin
         txn_valid <= 1'b0;
      end else begin
         txn_valid <= q_valid;
      end
   end

   always_ff @(posedge rx_clk) begin
      if (q_valid) begin
         txn <= txn_d;                 // held until next pop
      end
   end

endmodule

// File: hdl/mrx.sv
`timescale 1ns/1ps

// receive path top, pins to decoded transactions
module mrx #(
   parameter int NMIO       = 8,       // half the beat width
   parameter int FIFO_DEPTH = 4        // packet queue entries
) (
   input  logic              rx_clk,
   input  logic              nreset,
   input  logic [7:0]        datasize,  // beats per packet
   input  logic              lsbfirst,
   input  logic              io_access, // framing level
   input  logic [2*NMIO-1:0] io_packet,
   input  logic              rd,        // pop strobe
   output logic              txn_valid,
   output mrx_pkg::mrx_txn_t txn,
   output logic              empty,
   output logic              overflow
);

   import mrx_pkg::*;

   logic              access;          // sampled framing level
   logic [2*NMIO-1:0] beat;            // aligned beat
   logic              fifo_access;
   mrx_packet_t       fifo_packet;     // assembled packet
   logic              q_valid;
   mrx_packet_t       q_packet;        // popped head

   //############################
   // front end
   //############################

   mrx_io #(
      .NMIO (NMIO)
   ) i_io (
      .rx_clk    (rx_clk),
      .nreset    (nreset),
      .io_access (io_access),
      .io_packet (io_packet),
      .access    (access),
      .beat      (beat)
   );

   mrx_protocol #(
      .NMIO (NMIO)
   ) i_protocol (
      .rx_clk      (rx_clk),
      .nreset      (nreset),
      .datasize    (datasize),
      .lsbfirst    (lsbfirst),
      .access      (access),
      .beat        (beat),
      .fifo_access (fifo_access),
      .fifo_packet (fifo_packet)
   );

   //############################
   // queue and decode
   //############################

   mrx_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_fifo (
      .rx_clk    (rx_clk),
      .nreset    (nreset),
      .wr        (fifo_access),
      .wr_packet (fifo_packet),
      .rd        (rd),
      .q_valid   (q_valid),
      .q_packet  (q_packet),
      .empty     (empty),
      .overflow  (overflow)
   );

   mrx_unpack i_unpack (
      .rx_clk    (rx_clk),
      .nreset    (nreset),
      .q_valid   (q_valid),
      .q_packet  (q_packet),
      .txn_valid (txn_valid),
      .txn       (txn)
   );

endmodule

// File: verif/mrx_tb.sv
`timescale 1ns/1ps

// testbench for the mrx receive path
module mrx_tb;

   import mrx_pkg::*;

   localparam int NMIO       = 8;
   localparam int SW         = 2*NMIO;      // beat width
   localparam int NBEATS     = 7;           // datasize used by every test
   localparam int DEPTH      = 4;           // queue entries in the dut
   localparam int NPKT       = 29;          // packets sent over the whole run
   localparam int MAX_CYCLES = 100 * NPKT;  // generous per packet budget

   logic          rx_clk;
   logic          nreset;
   logic [7:0]    datasize;
   logic          lsbfirst;
   logic          io_access;
   logic [SW-1:0] io_packet;
   logic          rd;
   logic          txn_valid;
   mrx_txn_t      txn;
   logic          empty;
   logic          overflow;

   mrx_packet_t   exp_q [$];                // packets expected out of the queue
   logic          exp_overflow = 1'b0;
   logic          pop_d1 = 1'b0;            // accepted pop, one cycle back
   logic          pop_d2 = 1'b0;            // two cycles back
   logic          ovf_seen = 1'b0;
   int            cycles = 0;
   integer        seed = 6641;
   logic [31:0]   addr;
   logic [2:0]    offs [4] = '{3'd0, 3'd1, 3'd2, 3'd6}; // dstaddr low bits

   mrx #(
      .NMIO       (NMIO),
      .FIFO_DEPTH (DEPTH)
   ) i_dut (
      .rx_clk    (rx_clk),
      .nreset    (nreset),
      .datasize  (datasize),
      .lsbfirst  (lsbfirst),
      .io_access (io_access),
      .io_packet (io_packet),
      .rd        (rd),
      .txn_valid (txn_valid),
      .txn       (txn),
      .empty     (empty),
      .overflow  (overflow)
   );

   initial begin
      rx_clk = 1'b0;
      forever #5 rx_clk = ~rx_clk;  // 100 MHz
   end

   //############################
   // error helpers
   //############################

   task automatic abort(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] got);
      abort($sformatf("Fail at time %0t: %s expected 0x%0h got 0x%0h",
                      $time, name, exp, got));
   endtask

   //############################
   // reference model
   //############################

   // expected decode, straight from the size and lane rules
   function automatic mrx_txn_t expect_txn(input mrx_packet_t p);
      mrx_txn_t    t;
      logic [31:0] nbytes;
      logic [15:0] mask;
      nbytes      = 32'd1 << p.datamode;           // 1, 2, 4 or 8 bytes
      mask        = ((16'd1 << nbytes) - 16'd1) << p.dstaddr[2:0];
      t.cmd       = p.write;
      t.size      = p.datamode;
      t.ctrlmode  = p.ctrlmode;
      t.dstaddr   = p.dstaddr;
      t.data      = p.data;
      t.srcaddr   = p.srcaddr;
      t.bytemask  = mask[7:0];                     // lanes past 7 dropped
      t.align_err = (p.dstaddr % nbytes) != 32'd0;
      return t;
   endfunction

   function automatic mrx_packet_t make_packet(input logic wr, input mrx_size_t mode,
                                               input logic [31:0] dst);
      mrx_packet_t p;
      logic [31:0] r;
      r          = $random(seed);
      p.write    = mrx_cmd_t'(wr);
      p.datamode = mode;
      p.ctrlmode = r[4:0];
      p.dstaddr  = dst;
      p.data     = $random(seed);
      p.srcaddr  = $random(seed);
      return p;
   endfunction

   function automatic mrx_packet_t rand_packet();
      logic [31:0] r;
      r = $random(seed);
      return make_packet(r[0], mrx_size_t'(r[2:1]), $random(seed));
   endfunction

   // queue model, a full queue drops the packet
   task automatic push_expected(input mrx_packet_t p);
      if (exp_q.size() < DEPTH) begin
         exp_q.push_back(p);
      end else begin
         exp_overflow = 1'b1;
      end
   endtask

   //############################
   // stimulus
   //############################

   // one packet as NBEATS beats, io_access left high unless last
   task automatic send_packet(input mrx_packet_t p, input logic last);
      logic [NBEATS*SW-1:0]    stream;
      logic [NBEATS*SW-PW-1:0] pad;            // bits that fall off the shifter
      logic [PW-1:0]           model;
      logic [SW-1:0]           b;
      logic [31:0]             r;
      r   = $random(seed);
      pad = r[NBEATS*SW-PW-1:0];
      if (lsbfirst) begin
         stream = {p, pad};                     // pad leaves at the bottom
      end else begin
         stream = {pad, p};                     // pad leaves at the top
      end
      for (int i = 0; i < NBEATS; i++) begin
         if (lsbfirst) begin
            b     = stream[i*SW +: SW];
            model = {b, model[PW-1:SW]};        // down, new beat on top
         end else begin
            b     = stream[(NBEATS-1-i)*SW +: SW];
            model = {model[PW-SW-1:0], b};      // up, new beat at bottom
         end
         io_access <= 1'b1;
         io_packet <= b;
         @(posedge rx_clk);
      end
      if (last) begin
         io_access <= 1'b0;
      end
      push_expected(mrx_packet_t'(model));
   endtask

   task automatic send_burst(input int n);
      for (int i = 0; i < n; i++) begin
         send_packet(rand_packet(), i == n - 1);
      end
   endtask

   // single rd pulse once the queue holds something
   task automatic pop_one();
      while (empty) @(posedge rx_clk);
      rd <= 1'b1;
      @(posedge rx_clk);
      rd <= 1'b0;
      while (!txn_valid) @(posedge rx_clk);
      @(posedge rx_clk);
   endtask

   //############################
   // checkers
   //############################

   task automatic check_txn();
      mrx_txn_t e;
      if (exp_q.size() == 0) begin
         abort("txn_valid pulsed with no packet waiting in the queue model");
      end else begin
         e = expect_txn(exp_q.pop_front());
         assert (txn.cmd == e.cmd) else report_mismatch("txn.cmd", 64'(e.cmd), 64'(txn.cmd));
         assert (txn.size == e.size) else report_mismatch("txn.size", 64'(e.size), 64'(txn.size));
         assert (txn.ctrlmode == e.ctrlmode)
            else report_mismatch("txn.ctrlmode", 64'(e.ctrlmode), 64'(txn.ctrlmode));
         assert (txn.dstaddr == e.dstaddr)
            else report_mismatch("txn.dstaddr", 64'(e.dstaddr), 64'(txn.dstaddr));
         assert (txn.data == e.data) else report_mismatch("txn.data", 64'(e.data), 64'(txn.data));
         assert (txn.srcaddr == e.srcaddr)
            else report_mismatch("txn.srcaddr", 64'(e.srcaddr), 64'(txn.srcaddr));
         assert (txn.bytemask == e.bytemask)
            else report_mismatch("txn.bytemask", 64'(e.bytemask), 64'(txn.bytemask));
         assert (txn.align_err == e.align_err)
            else report_mismatch("txn.align_err", 64'(e.align_err), 64'(txn.align_err));
      end
   endtask

   // outputs settled mid cycle
   always @(negedge rx_clk) begin
      if (nreset) begin
         assert (txn_valid == pop_d2)
            else report_mismatch("txn_valid", 64'(pop_d2), 64'(txn_valid)); // rd plus 2
         if (txn_valid) begin
            check_txn();
         end
         assert (!(ovf_seen && !overflow)) else abort("overflow cleared without a reset");
         assert (!overflow || exp_overflow)
            else report_mismatch("overflow", 64'(exp_overflow), 64'(overflow)); // only after a drop
         ovf_seen = ovf_seen | overflow;
         pop_d2   = pop_d1;
         pop_d1   = rd && !empty;               // rd on empty queue is ignored
      end
   end

   always @(posedge rx_clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         abort("timeout, the run did not complete within the cycle limit");
      end
   end

   //############################
   // test sequence
   //############################

   initial begin
      nreset    = 1'b0;
      datasize  = 8'(NBEATS);
      lsbfirst  = 1'b0;
      io_access = 1'b0;
      io_packet = '0;
      rd        = 1'b0;
      repeat (10) @(posedge rx_clk);
      nreset <= 1'b1;
      @(posedge rx_clk);
      assert (empty == 1'b1) else report_mismatch("empty", 64'd1, 64'(empty));
      assert (overflow == 1'b0) else report_mismatch("overflow", 64'd0, 64'(overflow));

      // msb first, single then back to back
      send_burst(1);
      pop_one();
      send_burst(3);
      repeat (3) pop_one();

      // lsb first
      lsbfirst <= 1'b1;
      @(posedge rx_clk);
      send_burst(1);
      pop_one();
      send_burst(3);
      repeat (3) pop_one();

      // every size against aligned and misaligned addresses
      lsbfirst <= 1'b0;
      @(posedge rx_clk);
      for (int m = 0; m < 4; m++) begin
         for (int k = 0; k < 4; k++) begin
            addr      = $random(seed);
            addr[2:0] = offs[k];
            send_packet(make_packet(k[0] ^ m[0], mrx_size_t'(m[1:0]), addr), k == 3);
         end
         repeat (4) pop_one();
      end

      // five in without a pop, fifth is lost
      send_burst(5);
      while (!overflow) @(posedge rx_clk);
      repeat (DEPTH) pop_one();
      assert (empty == 1'b1) else report_mismatch("empty", 64'd1, 64'(empty));
      rd <= 1'b1;                               // pop on empty queue
      @(posedge rx_clk);
      rd <= 1'b0;
      repeat (4) @(posedge rx_clk);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: mrx.f
hdl/mrx_pkg.sv
hdl/mrx_io.sv
hdl/mrx_ser2par.sv
hdl/mrx_protocol.sv
hdl/mrx_fifo.sv
hdl/mrx_unpack.sv
hdl/mrx.sv
verif/mrx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mrx testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module mrx_tb -f mrx.f -o mrx_tb_sim \
   && ./obj_dir/mrx_tb_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
   && echo "run passed" \
   || { echo "run failed"; exit 1; }
